// File: include/alu_config.svh
// Width and depth macros for the execute datapath
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath word width
`define DATA_WIDTH 32

// Register file depth and index width
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// Opcode field width, sized for eight operations
`define ALU_OP_WIDTH 3

`endif

// File: source/alu_pkg.sv
// Package with the ALU opcode type
`include "alu_config.svh"

package alu_pkg;

  // Arithmetic ops sit in the low codes.
  // Logic ops come in complementary pairs so one inversion covers both.
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    OP_ADD  = 3'd0,  // a + b
    OP_SUB  = 3'd1,  // a + ~b + 1
    OP_XOR  = 3'd2,
    OP_SLT  = 3'd3,  // Signed a < b
    OP_AND  = 3'd4,
    OP_NAND = 3'd5,
    OP_NOR  = 3'd6,
    OP_OR   = 3'd7
  } alu_op_t;

endpackage

// File: source/alu_slice.sv
// One bit slice of the ALU with full adder, logic functions and result mux
`timescale 1ns/1ps

module alu_slice import alu_pkg::*; (
  input  logic    a,
  input  logic    b,
  input  logic    carry_in,
  input  alu_op_t op,
  input  logic    less,
  output logic    result,
  output logic    carry_out,
  output logic    sum
);

  logic invert_b;
  logic b_eff;
  logic xor_out;
  logic and_group;
  logic or_group;

  // Subtraction and compare both run a + ~b + 1
  assign invert_b = (op == OP_SUB) || (op == OP_SLT);
  assign b_eff    = b ^ invert_b;

  assign sum       = a ^ b_eff ^ carry_in;
  assign carry_out = (a & b_eff) | (a & carry_in) | (b_eff & carry_in);

  assign xor_out = a ^ b;

  // NAND and NOR are the inverted forms of AND and OR
  assign and_group = (a & b) ^ (op == OP_NAND);
  assign or_group  = (a | b) ^ (op == OP_NOR);

  // Five-input result mux
  always_comb begin
    case (op)
      OP_ADD, OP_SUB:   result = sum;
      OP_XOR:           result = xor_out;
      OP_SLT:           result = less;      // Only slice 0 sees a live bit here
      OP_AND, OP_NAND:  result = and_group;
      OP_NOR, OP_OR:    result = or_group;
      default:          result = 1'b0;
    endcase
  end

endmodule

// File: source/alu.sv
// 32-bit bit-sliced ALU with carry, overflow, set-less-than and zero logic
`timescale 1ns/1ps
`include "alu_config.svh"

module alu import alu_pkg::*; (
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  input  alu_op_t                op,
  output logic [`DATA_WIDTH-1:0] result,
  output logic                   carry,
  output logic                   overflow,
  output logic                   zero
);

  localparam int W = `DATA_WIDTH;

  logic [W:0]   carry_chain;  // Entry i feeds slice i, entry W is the final carry
  logic [W-1:0] sum_bits;
  logic [W-1:0] less_bits;
  logic         is_arith;
  logic         sub_carry_in;
  logic         adder_overflow;
  logic         slt_bit;

  // SUB and SLT add the one that completes the two's complement of b
  assign sub_carry_in   = (op == OP_SUB) || (op == OP_SLT);
  assign carry_chain[0] = sub_carry_in;

  // Only slice 0 gets the compare result, the upper bits of SLT read zero
  assign less_bits = {{(W-1){1'b0}}, slt_bit};

  genvar i;
  generate
    for (i = 0; i < W; i++) begin : gen_slice
      alu_slice slice_inst (
        .a         (a[i]),
        .b         (b[i]),
        .carry_in  (carry_chain[i]),
        .op        (op),
        .less      (less_bits[i]),
        .result    (result[i]),
        .carry_out (carry_chain[i+1]),
        .sum       (sum_bits[i])
      );
    end
  endgenerate

  // Signed overflow shows as a mismatch of carry into and out of the sign bit
  assign adder_overflow = carry_chain[W-1] ^ carry_chain[W];

  // Sign of a - b, corrected when the subtraction overflowed
  assign slt_bit = sum_bits[W-1] ^ adder_overflow;

  // Flags from the adder only mean something for ADD and SUB
  assign is_arith = (op == OP_ADD) || (op == OP_SUB);
  assign carry    = is_arith & carry_chain[W];  // High means no borrow on SUB
  assign overflow = is_arith & adder_overflow;

  assign zero = ~|result;

endmodule

// File: source/register_file.sv
// Register file with 32 words, write decode, zero register and two read ports
`timescale 1ns/1ps
`include "alu_config.svh"

module register_file (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       write_en,
  input  logic [`REG_ADDR_WIDTH-1:0] write_addr,
  input  logic [`DATA_WIDTH-1:0]     write_data,
  input  logic [`REG_ADDR_WIDTH-1:0] read_addr_a,
  input  logic [`REG_ADDR_WIDTH-1:0] read_addr_b,
  output logic [`DATA_WIDTH-1:0]     read_data_a,
  output logic [`DATA_WIDTH-1:0]     read_data_b
);

  // Register 0 has no storage, so there is nothing to write there
  logic [`DATA_WIDTH-1:0]   regs [1:`REG_COUNT-1];
  logic [`REG_COUNT-1:1]    write_sel;   // One-hot write enable per register
  logic [`DATA_WIDTH-1:0]   reg_bank [`REG_COUNT];

  // Write address decode
  always_comb begin
    for (int i = 1; i < `REG_COUNT; i++) begin
      write_sel[i] = write_en && (write_addr == `REG_ADDR_WIDTH'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `REG_COUNT; i++) begin
        if (write_sel[i]) begin
          regs[i] <= write_data;
        end
      end
    end
  end

  // Word view of all 32 inputs for the read muxes
  always_comb begin
    reg_bank[0] = '0;  // Hardwired zero
    for (int i = 1; i < `REG_COUNT; i++) begin
      reg_bank[i] = regs[i];
    end
  end

  // Two 32:1 word selections, reads are combinational
  assign read_data_a = reg_bank[read_addr_a];
  assign read_data_b = reg_bank[read_addr_b];

endmodule

// File: source/exec_datapath.sv
// Execute datapath top level with register file, ALU and result registers
`timescale 1ns/1ps
`include "alu_config.svh"

module exec_datapath import alu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       exec,
  input  alu_op_t                    op,
  input  logic [`REG_ADDR_WIDTH-1:0] rs,
  input  logic [`REG_ADDR_WIDTH-1:0] rt,
  input  logic [`REG_ADDR_WIDTH-1:0] rd,
  input  logic                       write_en,
  output logic                       done,
  output logic [`DATA_WIDTH-1:0]     result_q,
  output logic                       zero_q,
  output logic                       carry_q,
  output logic                       overflow_q
);

  logic [`DATA_WIDTH-1:0] rs_data;
  logic [`DATA_WIDTH-1:0] rt_data;
  logic [`DATA_WIDTH-1:0] alu_result;
  logic                   alu_carry;
  logic                   alu_overflow;
  logic                   alu_zero;
  logic                   rf_write;

  // Writeback happens on the same edge that samples exec
  assign rf_write = exec & write_en;

  register_file register_file_inst (
    .clk         (clk),
    .rst         (rst),
    .write_en    (rf_write),
    .write_addr  (rd),
    .write_data  (alu_result),
    .read_addr_a (rs),
    .read_addr_b (rt),
    .read_data_a (rs_data),
    .read_data_b (rt_data)
  );

  alu alu_inst (
    .a        (rs_data),
    .b        (rt_data),
    .op       (op),
    .result   (alu_result),
    .carry    (alu_carry),
    .overflow (alu_overflow),
    .zero     (alu_zero)
  );

  // Output registers hold the last result until the next exec
  always_ff @(posedge clk) begin
    if (rst) begin
      done       <= 1'b0;
      result_q   <= '0;
      zero_q     <= 1'b0;
      carry_q    <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      done <= exec;  // One pulse per strobe, back-to-back included
      if (exec) begin
        result_q   <= alu_result;
        zero_q     <= alu_zero;
        carry_q    <= alu_carry;
        overflow_q <= alu_overflow;
      end
    end
  end

endmodule

// File: test/exec_datapath_checker.sv
// Bound assertions on exec to done timing and registered flag consistency
`timescale 1ns/1ps
`include "alu_config.svh"

module exec_datapath_checker import alu_pkg::*; (
  input logic                   clk,
  input logic                   rst,
  input logic                   exec,
  input alu_op_t                op,
  input logic                   done,
  input logic [`DATA_WIDTH-1:0] result_q,
  input logic                   zero_q,
  input logic                   carry_q,
  input logic                   overflow_q
);

  int violation_count = 0;  // Read by the testbench at the end of the run

  // Every exec gives a done on the next cycle
  done_after_exec: assert property (@(posedge clk) disable iff (rst) exec |=> done)
    else begin
      violation_count++;
      $error("done did not follow exec by one cycle");
    end

  // No done without an exec one cycle earlier
  done_needs_exec: assert property (@(posedge clk) disable iff (rst) done |-> $past(exec))
    else begin
      violation_count++;
      $error("done was raised without a preceding exec");
    end

  zero_consistent: assert property (@(posedge clk) disable iff (rst)
      done |-> (zero_q == (result_q == '0)))
    else begin
      violation_count++;
      $error("zero_q does not match the registered result");
    end

  // Logic ops and SLT never raise the adder flags
  logic_flags_low: assert property (@(posedge clk) disable iff (rst)
      (done && !($past(op) inside {OP_ADD, OP_SUB})) |-> (!carry_q && !overflow_q))
    else begin
      violation_count++;
      $error("carry_q or overflow_q set after a non-arithmetic op");
    end

endmodule

bind exec_datapath exec_datapath_checker checker_inst (
  .clk        (clk),
  .rst        (rst),
  .exec       (exec),
  .op         (op),
  .done       (done),
  .result_q   (result_q),
  .zero_q     (zero_q),
  .carry_q    (carry_q),
  .overflow_q (overflow_q)
);

// File: test/exec_datapath_tb.sv
// Testbench for the execute datapath, driven and checked from a trace file
`timescale 1ns/1ps
`include "alu_config.svh"

module exec_datapath_tb import alu_pkg::*; ();

  localparam string TRACE_PATH = "test/exec_datapath_trace.txt";

  logic                       clk;
  logic                       rst;
  logic                       exec;
  alu_op_t                    op;
  logic [`REG_ADDR_WIDTH-1:0] rs;
  logic [`REG_ADDR_WIDTH-1:0] rt;
  logic [`REG_ADDR_WIDTH-1:0] rd;
  logic                       write_en;
  logic                       done;
  logic [`DATA_WIDTH-1:0]     result_q;
  logic                       zero_q;
  logic                       carry_q;
  logic                       overflow_q;

  // One entry per trace line
  string                      name_q[$];
  alu_op_t                    op_q[$];
  logic [`REG_ADDR_WIDTH-1:0] rs_q[$];
  logic [`REG_ADDR_WIDTH-1:0] rt_q[$];
  logic [`REG_ADDR_WIDTH-1:0] rd_q[$];
  logic                       we_q[$];
  logic [`DATA_WIDTH-1:0]     exp_result_q[$];
  logic                       exp_zero_q[$];
  logic                       exp_carry_q[$];
  logic                       exp_overflow_q[$];

  int cycle_count = 0;
  int cycle_limit = 0;  // Armed once the trace length is known

  exec_datapath exec_datapath_inst (
    .clk        (clk),
    .rst        (rst),
    .exec       (exec),
    .op         (op),
    .rs         (rs),
    .rt         (rt),
    .rd         (rd),
    .write_en   (write_en),
    .done       (done),
    .result_q   (result_q),
    .zero_q     (zero_q),
    .carry_q    (carry_q),
    .overflow_q (overflow_q)
  );

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      abort_run($sformatf("Timeout, run did not finish within %0d cycles", cycle_limit));
    end
  end

  // Bound checker failures end the run at the next falling edge
  always @(negedge clk) begin
    if (exec_datapath_inst.checker_inst.violation_count != 0) begin
      abort_run("The bound checker reported an assertion failure");
    end
  end

  task automatic abort_run(input string reason);
    $display("ERROR: %s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test, field, expected, actual);
      abort_run("Output does not match the trace");
    end
  endtask

  // Opcode mnemonics as written in the trace
  task automatic decode_op(input string name, output alu_op_t code, output bit ok);
    ok = 1'b1;
    code = OP_ADD;
    case (name)
      "ADD":   code = OP_ADD;
      "SUB":   code = OP_SUB;
      "XOR":   code = OP_XOR;
      "SLT":   code = OP_SLT;
      "AND":   code = OP_AND;
      "NAND":  code = OP_NAND;
      "NOR":   code = OP_NOR;
      "OR":    code = OP_OR;
      default: ok = 1'b0;
    endcase
  endtask

  task automatic load_trace();
    int          fd;
    int          fields;
    string       line;
    string       test_name;
    string       op_name;
    int          rs_i;
    int          rt_i;
    int          rd_i;
    int          we_i;
    int          zero_i;
    int          carry_i;
    int          ovf_i;
    logic [31:0] result_i;
    alu_op_t     op_val;
    bit          op_ok;

    fd = $fopen(TRACE_PATH, "r");
    if (fd == 0) begin
      abort_run({"Cannot open the trace file ", TRACE_PATH});
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin  // Skip blank and comment lines
        fields = $sscanf(line, "%s %s %d %d %d %d %h %d %d %d", test_name, op_name,
                         rs_i, rt_i, rd_i, we_i, result_i, zero_i, carry_i, ovf_i);
        if (fields != 10) begin
          abort_run({"Malformed trace line: ", line});
        end
        decode_op(op_name, op_val, op_ok);
        if (!op_ok) begin
          abort_run({"Unknown opcode in the trace: ", op_name});
        end
        if (rs_i >= `REG_COUNT || rt_i >= `REG_COUNT || rd_i >= `REG_COUNT) begin
          abort_run({"Register number out of range in test ", test_name});
        end
        name_q.push_back(test_name);
        op_q.push_back(op_val);
        rs_q.push_back(`REG_ADDR_WIDTH'(rs_i));
        rt_q.push_back(`REG_ADDR_WIDTH'(rt_i));
        rd_q.push_back(`REG_ADDR_WIDTH'(rd_i));
        we_q.push_back(we_i != 0);
        exp_result_q.push_back(result_i);
        exp_zero_q.push_back(zero_i != 0);
        exp_carry_q.push_back(carry_i != 0);
        exp_overflow_q.push_back(ovf_i != 0);
      end
    end
    $fclose(fd);
    if (name_q.size() == 0) begin
      abort_run("The trace file holds no test lines");
    end
  endtask

  initial begin : stimulus
    clk      = 1'b0;
    rst      = 1'b1;
    exec     = 1'b0;
    op       = OP_ADD;
    rs       = '0;
    rt       = '0;
    rd       = '0;
    write_en = 1'b0;

    load_trace();
    cycle_limit = 4 * name_q.size() + 20;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Lines issue back to back, the next one goes out on the checking edge
    for (int i = 0; i < name_q.size(); i++) begin
      exec     = 1'b1;
      op       = op_q[i];
      rs       = rs_q[i];
      rt       = rt_q[i];
      rd       = rd_q[i];
      write_en = we_q[i];
      @(posedge clk);
      @(negedge clk);
      while (!done) begin
        exec = 1'b0;  // Hold off new work until done shows
        @(negedge clk);
      end
      check_field(name_q[i], "result", exp_result_q[i], result_q);
      check_field(name_q[i], "zero", exp_zero_q[i], zero_q);
      check_field(name_q[i], "carry", exp_carry_q[i], carry_q);
      check_field(name_q[i], "overflow", exp_overflow_q[i], overflow_q);
    end
    exec     = 1'b0;
    write_en = 1'b0;
    repeat (2) @(negedge clk);
    check_field("idle", "done", 1'b0, done);  // No pulse without a strobe

    if (exec_datapath_inst.checker_inst.violation_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("The bound checker reported assertion failures");
    end
  end

endmodule

// File: filelist.f
+incdir+include
source/alu_pkg.sv
source/alu_slice.sv
source/alu.sv
source/register_file.sv
source/exec_datapath.sv
test/exec_datapath_checker.sv
test/exec_datapath_tb.sv

// File: test/exec_datapath_trace.txt
# name op rs rt rd write_en result zero carry overflow
# Register numbers in decimal, result in hex, flags 0 or 1
# Seed values from r0
seed_ones NOR 0 0 1 1 FFFFFFFF 0 0 0
seed_one SUB 0 1 2 1 00000001 0 0 0
# Doubling chain in r3, each line reads the previous write
dbl_01 ADD 2 2 3 1 00000002 0 0 0
dbl_02 ADD 3 3 3 1 00000004 0 0 0
dbl_03 ADD 3 3 3 1 00000008 0 0 0
dbl_04 ADD 3 3 3 1 00000010 0 0 0
dbl_05 ADD 3 3 3 1 00000020 0 0 0
dbl_06 ADD 3 3 3 1 00000040 0 0 0
dbl_07 ADD 3 3 3 1 00000080 0 0 0
dbl_08 ADD 3 3 3 1 00000100 0 0 0
dbl_09 ADD 3 3 3 1 00000200 0 0 0
dbl_10 ADD 3 3 3 1 00000400 0 0 0
dbl_11 ADD 3 3 3 1 00000800 0 0 0
dbl_12 ADD 3 3 3 1 00001000 0 0 0
dbl_13 ADD 3 3 3 1 00002000 0 0 0
dbl_14 ADD 3 3 3 1 00004000 0 0 0
dbl_15 ADD 3 3 3 1 00008000 0 0 0
dbl_16 ADD 3 3 3 1 00010000 0 0 0
dbl_17 ADD 3 3 3 1 00020000 0 0 0
dbl_18 ADD 3 3 3 1 00040000 0 0 0
dbl_19 ADD 3 3 3 1 00080000 0 0 0
dbl_20 ADD 3 3 3 1 00100000 0 0 0
dbl_21 ADD 3 3 3 1 00200000 0 0 0
dbl_22 ADD 3 3 3 1 00400000 0 0 0
dbl_23 ADD 3 3 3 1 00800000 0 0 0
dbl_24 ADD 3 3 3 1 01000000 0 0 0
dbl_25 ADD 3 3 3 1 02000000 0 0 0
dbl_26 ADD 3 3 3 1 04000000 0 0 0
dbl_27 ADD 3 3 3 1 08000000 0 0 0
dbl_28 ADD 3 3 3 1 10000000 0 0 0
dbl_29 ADD 3 3 3 1 20000000 0 0 0
dbl_30 ADD 3 3 3 1 40000000 0 0 0
# Arithmetic flags
add_ovf_pos ADD 3 3 4 1 80000000 0 0 1
sub_ovf_neg SUB 4 2 5 1 7FFFFFFF 0 1 1
add_ovf_max ADD 5 2 6 1 80000000 0 0 1
add_carry_wrap ADD 1 2 7 1 00000000 1 1 0
sub_equal SUB 2 2 9 1 00000000 1 1 0
sub_borrow SUB 2 3 8 1 C0000001 0 0 0
add_ovf_neg ADD 4 4 10 1 00000000 1 1 1
sub_pos_neg SUB 2 1 11 1 00000002 0 0 0
# Read-back with rt = r0
rb_r1 ADD 1 0 0 0 FFFFFFFF 0 0 0
rb_r2 ADD 2 0 0 0 00000001 0 0 0
rb_r3 ADD 3 0 0 0 40000000 0 0 0
rb_r4 ADD 4 0 0 0 80000000 0 0 0
rb_r5 ADD 5 0 0 0 7FFFFFFF 0 0 0
rb_r8 ADD 8 0 0 0 C0000001 0 0 0
# Logic ops
xor_mixed XOR 5 8 12 1 BFFFFFFE 0 0 0
xor_self XOR 8 8 13 1 00000000 1 0 0
and_mixed AND 5 8 14 1 40000001 0 0 0
and_disjoint AND 4 5 15 1 00000000 1 0 0
nand_mixed NAND 5 8 16 1 BFFFFFFE 0 0 0
nand_ones NAND 1 1 17 1 00000000 1 0 0
nor_mixed NOR 3 2 18 1 BFFFFFFE 0 0 0
nor_zero NOR 8 5 19 1 00000000 1 0 0
or_mixed OR 12 3 20 1 FFFFFFFE 0 0 0
# Signed compare
slt_neg_pos SLT 1 2 22 1 00000001 0 0 0
slt_equal SLT 2 2 23 1 00000000 1 0 0
slt_pos_neg SLT 2 1 24 1 00000000 1 0 0
slt_min_max SLT 4 5 25 1 00000001 0 0 0
slt_max_min SLT 5 4 26 1 00000000 1 0 0
# Register 0 and write_en low
r0_write ADD 2 2 0 1 00000002 0 0 0
r0_read ADD 0 0 27 1 00000000 1 0 0
we_low ADD 1 1 2 0 FFFFFFFE 0 1 0
we_low_read ADD 2 0 0 0 00000001 0 0 0
# Back-to-back dependency
b2b_write SUB 0 2 28 1 FFFFFFFF 0 0 0
b2b_read XOR 28 1 29 1 00000000 1 0 0
b2b_chain ADD 29 2 30 1 00000001 0 0 0
